//--- Bender.yml
package:
  name: exec_unit

sources:
  - rtl/exec_pkg.sv
  - rtl/mul_stage_if.sv
  - rtl/int_alu.sv
  - rtl/branch_unit.sv
  - rtl/mul_stage.sv
  - rtl/mul_pipe.sv
  - rtl/exec_unit.sv
  - target: test
    files:
      - verification/exec_unit_properties.sv
      - verification/exec_unit_tb.sv

//--- rtl/branch_unit.sv
module branch_unit (
  input  exec_pkg::br_cond_e cond,
  input  exec_pkg::data_t    a,
  input  exec_pkg::data_t    npc,
  input  exec_pkg::disp_t    disp,
  output logic               taken,
  output exec_pkg::data_t    target
);
  import exec_pkg::*;

  localparam int disp_w = $bits(disp_t);

  logic  base;
  logic  a_zero;
  logic  a_neg;
  data_t disp_ext;

  assign a_zero = (a == '0);
  assign a_neg  = a[data_w-1];

  always_comb begin
    case (cond[1:0])
      2'b00:   base = ~a[0];           // low bit clear
      2'b01:   base = a_zero;
      2'b10:   base = a_neg;
      default: base = a_neg || a_zero;
    endcase
  end

  assign taken = (cond == br_always) || (base ^ cond[2]);

  // word displacement, sign-extended
  assign disp_ext = {{(data_w - disp_w - 2){disp[disp_w-1]}}, disp, 2'b00};
  assign target   = npc + disp_ext;

endmodule

//--- rtl/exec_pkg.sv
package exec_pkg;

  localparam int data_w    = 64;
  localparam int rob_depth = 32;

  typedef logic [data_w-1:0]            data_t;
  typedef logic [$clog2(rob_depth)-1:0] rob_idx_t;
  typedef logic [7:0]                   lit_t;
  typedef logic [20:0]                  disp_t;

  typedef enum logic [4:0] {
    op_addq,
    op_subq,
    op_and,
    op_bic,
    op_bis,
    op_ornot,
    op_xor,
    op_eqv,
    op_srl,
    op_sll,
    op_sra,
    op_cmpult,
    op_cmpeq,
    op_cmpule,
    op_cmplt,
    op_cmple,
    op_mulq,
    op_br
  } exec_op_e;

  // bit 2 negates the base test on bits 1:0
  typedef enum logic [3:0] {
    br_lbc    = 4'h0,
    br_eq     = 4'h1,
    br_lt     = 4'h2,
    br_le     = 4'h3,
    br_lbs    = 4'h4,
    br_ne     = 4'h5,
    br_ge     = 4'h6,
    br_gt     = 4'h7,
    br_always = 4'h8
  } br_cond_e;

  // true when entry sits after branch and no later than tail, modulo rob_depth
  function automatic logic is_younger(
    input rob_idx_t entry,
    input rob_idx_t branch,
    input rob_idx_t tail
  );
    rob_idx_t entry_dist;
    rob_idx_t tail_dist;
    entry_dist = entry - branch;
    tail_dist  = tail - branch;
    return (entry_dist != '0) && (entry_dist <= tail_dist);
  endfunction

endpackage

//--- rtl/exec_unit.sv
module exec_unit #(
  parameter int num_mul_stages = 8
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               issue_valid,
  output logic               issue_ready,
  input  exec_pkg::exec_op_e issue_op,
  input  exec_pkg::br_cond_e issue_cond,
  input  exec_pkg::data_t    issue_a,
  input  exec_pkg::data_t    issue_b,
  input  logic               issue_use_lit,
  input  exec_pkg::lit_t     issue_lit,
  input  exec_pkg::disp_t    issue_disp,
  input  exec_pkg::data_t    issue_npc,
  input  exec_pkg::rob_idx_t issue_rob_idx,
  output logic               alu_valid,
  input  logic               alu_ready,
  output exec_pkg::data_t    alu_result,
  output exec_pkg::rob_idx_t alu_rob_idx,
  output logic               mul_valid,
  input  logic               mul_ready,
  output exec_pkg::data_t    mul_result,
  output exec_pkg::rob_idx_t mul_rob_idx,
  output logic               br_valid,
  output logic               br_taken,
  output exec_pkg::data_t    br_target,
  output exec_pkg::rob_idx_t br_rob_idx,
  input  exec_pkg::rob_idx_t rob_tail_idx
);
  import exec_pkg::*;

  logic  is_mul;
  logic  is_br;
  logic  route_ready;
  logic  mul_advance;
  logic  rollback;
  logic  issue_fire;
  logic  alu_fire;
  logic  br_fire;
  logic  alu_kill;
  data_t alu_out;
  logic  br_taken_c;
  data_t br_target_c;

  assign is_mul = (issue_op == op_mulq);
  assign is_br  = (issue_op == op_br);

  always_comb begin
    if (is_mul) begin
      route_ready = mul_advance;
    end else if (is_br) begin
      route_ready = 1'b1;
    end else begin
      route_ready = !alu_valid || alu_ready;
    end
  end

  assign issue_ready = !reset && route_ready;

  assign rollback   = br_valid && br_taken;
  assign issue_fire = issue_valid && issue_ready && !rollback;  // wrong-path issue dropped
  assign alu_fire   = issue_fire && !is_mul && !is_br;
  assign br_fire    = issue_fire && is_br;
  assign alu_kill   = rollback && is_younger(alu_rob_idx, br_rob_idx, rob_tail_idx);

  int_alu alu_i (
    .op     (issue_op),
    .a      (issue_a),
    .b      (issue_b),
    .use_lit(issue_use_lit),
    .lit    (issue_lit),
    .result (alu_out)
  );

  branch_unit br_i (
    .cond  (issue_cond),
    .a     (issue_a),
    .npc   (issue_npc),
    .disp  (issue_disp),
    .taken (br_taken_c),
    .target(br_target_c)
  );

  mul_pipe #(
    .num_mul_stages(num_mul_stages)
  ) mul_i (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (issue_fire && is_mul),
    .a          (issue_a),
    .b          (issue_b),
    .use_lit    (issue_use_lit),
    .lit        (issue_lit),
    .rob_idx    (issue_rob_idx),
    .squash     (rollback),
    .branch_idx (br_rob_idx),
    .tail_idx   (rob_tail_idx),
    .out_valid  (mul_valid),
    .out_ready  (mul_ready),
    .result     (mul_result),
    .out_rob_idx(mul_rob_idx),
    .advance    (mul_advance)
  );

  // alu result register, holds under back-pressure
  always_ff @(posedge clock) begin
    if (reset) begin
      alu_valid <= 1'b0;
    end else if (alu_fire) begin
      alu_valid <= 1'b1;
    end else if (alu_ready || alu_kill) begin
      alu_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (alu_fire) begin
      alu_result  <= alu_out;
      alu_rob_idx <= issue_rob_idx;
    end
  end

  // branch outcome is a one-cycle broadcast
  always_ff @(posedge clock) begin
    if (reset) begin
      br_valid <= 1'b0;
    end else begin
      br_valid <= br_fire;
    end
  end

  always_ff @(posedge clock) begin
    if (br_fire) begin
      br_taken   <= br_taken_c;
      br_target  <= br_target_c;
      br_rob_idx <= issue_rob_idx;
    end
  end

endmodule

//--- rtl/int_alu.sv
module int_alu (
  input  exec_pkg::exec_op_e op,
  input  exec_pkg::data_t    a,
  input  exec_pkg::data_t    b,
  input  logic               use_lit,
  input  exec_pkg::lit_t     lit,
  output exec_pkg::data_t    result
);
  import exec_pkg::*;

  data_t opb;
  logic  lt_s;
  logic  eq;

  assign opb = use_lit ? data_t'(lit) : b;  // literal is zero-extended
  assign eq  = (a == opb);

  // same sign: unsigned compare works; else a is less when negative
  always_comb begin
    if (a[data_w-1] == opb[data_w-1]) begin
      lt_s = (a < opb);
    end else begin
      lt_s = a[data_w-1];
    end
  end

  always_comb begin
    case (op)
      op_addq:   result = a + opb;
      op_subq:   result = a - opb;
      op_and:    result = a & opb;
      op_bic:    result = a & ~opb;
      op_bis:    result = a | opb;
      op_ornot:  result = a | ~opb;
      op_xor:    result = a ^ opb;
      op_eqv:    result = a ^ ~opb;
      op_srl:    result = a >> opb[5:0];
      op_sll:    result = a << opb[5:0];
      op_sra:    result = $signed(a) >>> opb[5:0];
      op_cmpult: result = data_t'(a < opb);
      op_cmpeq:  result = data_t'(eq);
      op_cmpule: result = data_t'((a < opb) || eq);
      op_cmplt:  result = data_t'(lt_s);
      op_cmple:  result = data_t'(lt_s || eq);
      default:   result = '0;  // mulq and br never land here
    endcase
  end

endmodule

//--- rtl/mul_pipe.sv
module mul_pipe #(
  parameter int num_mul_stages = 8
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               in_valid,
  input  exec_pkg::data_t    a,
  input  exec_pkg::data_t    b,
  input  logic               use_lit,
  input  exec_pkg::lit_t     lit,
  input  exec_pkg::rob_idx_t rob_idx,
  input  logic               squash,
  input  exec_pkg::rob_idx_t branch_idx,
  input  exec_pkg::rob_idx_t tail_idx,
  output logic               out_valid,
  input  logic               out_ready,
  output exec_pkg::data_t    result,
  output exec_pkg::rob_idx_t out_rob_idx,
  output logic               advance
);
  import exec_pkg::*;

  mul_stage_if link [num_mul_stages+1] ();

  // stage 0 input
  assign link[0].valid   = in_valid;
  assign link[0].product = '0;
  assign link[0].mplier  = a;
  assign link[0].mcand   = use_lit ? data_t'(lit) : b;
  assign link[0].rob_idx = rob_idx;

  // whole pipe stalls on an unaccepted result
  assign advance = !link[num_mul_stages].valid || out_ready;

  for (genvar i = 0; i < num_mul_stages; i++) begin : g_stage
    mul_stage #(
      .num_mul_stages(num_mul_stages)
    ) stage_i (
      .clock     (clock),
      .reset     (reset),
      .advance   (advance),
      .squash    (squash),
      .branch_idx(branch_idx),
      .tail_idx  (tail_idx),
      .up        (link[i].dst),
      .down      (link[i+1].src)
    );
  end

  assign out_valid   = link[num_mul_stages].valid;
  assign result      = link[num_mul_stages].product;
  assign out_rob_idx = link[num_mul_stages].rob_idx;

endmodule

//--- rtl/mul_stage.sv
module mul_stage #(
  parameter int num_mul_stages = 8
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               advance,
  input  logic               squash,
  input  exec_pkg::rob_idx_t branch_idx,
  input  exec_pkg::rob_idx_t tail_idx,
  mul_stage_if.dst           up,
  mul_stage_if.src           down
);
  import exec_pkg::*;

  localparam int chunk_w = data_w / num_mul_stages;

  logic     valid_q;
  data_t    product_q;
  data_t    mplier_q;
  data_t    mcand_q;
  rob_idx_t rob_idx_q;
  data_t    partial;
  logic     kill_up;
  logic     kill_held;

  assign partial   = up.mplier[chunk_w-1:0] * up.mcand;
  assign kill_up   = squash && is_younger(up.rob_idx, branch_idx, tail_idx);
  assign kill_held = squash && is_younger(rob_idx_q, branch_idx, tail_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (advance) begin
      valid_q <= up.valid && !kill_up;
    end else if (kill_held) begin
      valid_q <= 1'b0;
    end
  end

  // payload only moves with the pipe
  always_ff @(posedge clock) begin
    if (advance) begin
      product_q <= up.product + partial;
      mplier_q  <= up.mplier >> chunk_w;
      mcand_q   <= up.mcand << chunk_w;
      rob_idx_q <= up.rob_idx;
    end
  end

  assign down.valid   = valid_q;
  assign down.product = product_q;
  assign down.mplier  = mplier_q;
  assign down.mcand   = mcand_q;
  assign down.rob_idx = rob_idx_q;

endmodule

//--- rtl/mul_stage_if.sv
interface mul_stage_if;
  import exec_pkg::*;

  logic     valid;
  data_t    product;  // running sum of partial products
  data_t    mplier;   // unconsumed multiplier bits, low end next
  data_t    mcand;    // multiplicand, pre-shifted
  rob_idx_t rob_idx;

  modport src (
    output valid,
    output product,
    output mplier,
    output mcand,
    output rob_idx
  );

  modport dst (
    input valid,
    input product,
    input mplier,
    input mcand,
    input rob_idx
  );

endinterface

//--- tb.f
rtl/exec_pkg.sv
rtl/mul_stage_if.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/mul_stage.sv
rtl/mul_pipe.sv
rtl/exec_unit.sv
verification/exec_unit_properties.sv
verification/exec_unit_tb.sv

//--- verification/exec_unit_properties.sv
module exec_unit_properties (
  input logic               clock,
  input logic               reset,
  input logic               issue_ready,
  input logic               alu_valid,
  input logic               alu_ready,
  input exec_pkg::data_t    alu_result,
  input exec_pkg::rob_idx_t alu_rob_idx,
  input logic               mul_valid,
  input logic               mul_ready,
  input exec_pkg::data_t    mul_result,
  input exec_pkg::rob_idx_t mul_rob_idx,
  input logic               br_valid,
  input logic               br_taken
);
  int   fail_count = 0;
  logic rollback;

  assign rollback = br_valid && br_taken;  // may squash a held result

  alu_hold: assert property (@(posedge clock) disable iff (reset)
    alu_valid && !alu_ready && !rollback |=>
      alu_valid && $stable(alu_result) && $stable(alu_rob_idx))
  else begin
    $error("alu result changed before alu_ready");
    fail_count++;
  end

  mul_hold: assert property (@(posedge clock) disable iff (reset)
    mul_valid && !mul_ready && !rollback |=>
      mul_valid && $stable(mul_result) && $stable(mul_rob_idx))
  else begin
    $error("mul result changed before mul_ready");
    fail_count++;
  end

  br_pulse: assert property (@(posedge clock) disable iff (reset) br_valid |=> !br_valid)
  else begin
    $error("br_valid longer than one cycle");
    fail_count++;
  end

  ready_in_reset: assert property (@(posedge clock) reset |-> !issue_ready)
  else begin
    $error("issue_ready high during reset");
    fail_count++;
  end

endmodule

bind exec_unit exec_unit_properties props_i (
  .clock      (clock),
  .reset      (reset),
  .issue_ready(issue_ready),
  .alu_valid  (alu_valid),
  .alu_ready  (alu_ready),
  .alu_result (alu_result),
  .alu_rob_idx(alu_rob_idx),
  .mul_valid  (mul_valid),
  .mul_ready  (mul_ready),
  .mul_result (mul_result),
  .mul_rob_idx(mul_rob_idx),
  .br_valid   (br_valid),
  .br_taken   (br_taken)
);

//--- verification/exec_unit_tb.sv
module exec_unit_tb;
  import exec_pkg::*;

  localparam int num_mul_stages = 8;
  localparam int timeout_cycles = 1000;

  typedef struct {
    data_t    value;
    rob_idx_t rob;
    logic     taken;
    int       cycle;  // arrival cycle, mul only
  } result_t;

  logic     clock;
  logic     reset;
  logic     issue_valid;
  logic     issue_ready;
  exec_op_e issue_op;
  br_cond_e issue_cond;
  data_t    issue_a;
  data_t    issue_b;
  logic     issue_use_lit;
  lit_t     issue_lit;
  disp_t    issue_disp;
  data_t    issue_npc;
  rob_idx_t issue_rob_idx;
  logic     alu_valid;
  logic     alu_ready;
  data_t    alu_result;
  rob_idx_t alu_rob_idx;
  logic     mul_valid;
  logic     mul_ready;
  data_t    mul_result;
  rob_idx_t mul_rob_idx;
  logic     br_valid;
  logic     br_taken;
  data_t    br_target;
  rob_idx_t br_rob_idx;
  rob_idx_t rob_tail_idx;

  result_t  exp_alu[$];
  result_t  got_alu[$];
  result_t  exp_mul[$];
  result_t  got_mul[$];
  result_t  exp_br[$];
  result_t  got_br[$];

  data_t    rng_state     = 64'd3;
  data_t    ready_state   = 64'd3;
  logic     random_ready  = 1'b0;
  logic     check_latency = 1'b0;
  int       cycle         = 0;
  rob_idx_t next_rob      = '0;
  string    test_name     = "reset";

  exec_unit #(
    .num_mul_stages(num_mul_stages)
  ) dut_i (.*);

  always #2 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  function automatic data_t xorshift(data_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  function automatic data_t rand64();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic rob_idx_t fresh_rob();
    fresh_rob = next_rob;
    next_rob  = next_rob + 1'b1;
  endfunction

  function automatic data_t alu_model(exec_op_e op, data_t a, data_t b);
    case (op)
      op_addq:   return a + b;
      op_subq:   return a - b;
      op_and:    return a & b;
      op_bic:    return a & ~b;
      op_bis:    return a | b;
      op_ornot:  return a | ~b;
      op_xor:    return a ^ b;
      op_eqv:    return ~(a ^ b);
      op_srl:    return a >> b[5:0];
      op_sll:    return a << b[5:0];
      op_sra:    return $signed(a) >>> b[5:0];
      op_cmpult: return (a < b) ? 64'd1 : 64'd0;
      op_cmpeq:  return (a == b) ? 64'd1 : 64'd0;
      op_cmpule: return (a <= b) ? 64'd1 : 64'd0;
      op_cmplt:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      op_cmple:  return ($signed(a) <= $signed(b)) ? 64'd1 : 64'd0;
      default:   return '0;
    endcase
  endfunction

  function automatic logic br_taken_model(br_cond_e cond, data_t a);
    case (cond)
      br_lbc:  return !a[0];
      br_eq:   return a == '0;
      br_lt:   return $signed(a) < 0;
      br_le:   return $signed(a) <= 0;
      br_lbs:  return a[0];
      br_ne:   return a != '0;
      br_ge:   return $signed(a) >= 0;
      br_gt:   return $signed(a) > 0;
      default: return 1'b1;
    endcase
  endfunction

  // age test against the tail, distances in int
  function automatic logic after_branch(rob_idx_t entry, rob_idx_t branch, rob_idx_t tail);
    int entry_dist;
    int tail_dist;
    entry_dist = (int'(entry) - int'(branch) + rob_depth) % rob_depth;
    tail_dist  = (int'(tail) - int'(branch) + rob_depth) % rob_depth;
    return (entry_dist > 0) && (entry_dist <= tail_dist);
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (exp !== act) fail_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_rob(string name, rob_idx_t exp, rob_idx_t act);
    if (exp !== act) fail_run($sformatf("error %s: expected %0d, actual %0d", name, exp, act));
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) fail_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  // results are taken at negedge, the handshake completes at the next posedge
  always @(negedge clock) begin : monitor
    result_t r;
    logic    exp_ready;
    if (reset) exp_ready = 1'b0;
    else if (issue_op == op_mulq) exp_ready = !(mul_valid && !mul_ready);
    else if (issue_op == op_br) exp_ready = 1'b1;
    else exp_ready = !alu_valid || alu_ready;
    check_bit({test_name, " issue_ready"}, exp_ready, issue_ready);
    if (dut_i.props_i.fail_count != 0) fail_run("a handshake assertion failed");
    r.taken = 1'b0;
    r.cycle = cycle;
    if (!reset && alu_valid && alu_ready) begin
      r.value = alu_result;
      r.rob   = alu_rob_idx;
      got_alu.push_back(r);
    end
    if (!reset && mul_valid && mul_ready) begin
      r.value = mul_result;
      r.rob   = mul_rob_idx;
      got_mul.push_back(r);
    end
    if (!reset && br_valid) begin
      r.value = br_target;
      r.rob   = br_rob_idx;
      r.taken = br_taken;
      got_br.push_back(r);
    end
  end

  always @(posedge clock) begin
    if (random_ready) begin
      ready_state = xorshift(ready_state);
      alu_ready <= ready_state[3];
      mul_ready <= ready_state[5];
    end
  end

  task automatic issue(exec_op_e op, br_cond_e cond, data_t a, data_t b, logic use_lit,
                       lit_t lit, disp_t disp, data_t npc, rob_idx_t rob);
    int      waited;
    int      accept_cycle;
    longint  disp_ext;
    data_t   opb;
    result_t r;
    issue_valid   <= 1'b1;
    issue_op      <= op;
    issue_cond    <= cond;
    issue_a       <= a;
    issue_b       <= b;
    issue_use_lit <= use_lit;
    issue_lit     <= lit;
    issue_disp    <= disp;
    issue_npc     <= npc;
    issue_rob_idx <= rob;
    waited = 0;
    @(negedge clock);
    while (!issue_ready) begin
      if (waited >= timeout_cycles) begin
        fail_run("timed out waiting for issue_ready");
      end else begin
        waited++;
        @(negedge clock);
      end
    end
    accept_cycle = cycle;
    @(posedge clock);
    opb      = use_lit ? data_t'(lit) : b;
    disp_ext = $signed(disp);
    r.rob    = rob;
    r.taken  = 1'b0;
    r.cycle  = accept_cycle + num_mul_stages;
    if (op == op_mulq) begin
      r.value = a * opb;  // low 64 bits
      exp_mul.push_back(r);
    end else if (op == op_br) begin
      r.value = npc + data_t'(disp_ext * 4);
      r.taken = br_taken_model(cond, a);
      exp_br.push_back(r);
    end else begin
      r.value = alu_model(op, a, opb);
      exp_alu.push_back(r);
    end
  endtask

  task automatic idle();
    issue_valid <= 1'b0;
    @(posedge clock);
  endtask

  task automatic compare_results(string name);
    if (got_alu.size() != exp_alu.size())
      fail_run($sformatf("error %s: expected %0d alu results, actual %0d", name,
                         exp_alu.size(), got_alu.size()));
    if (got_mul.size() != exp_mul.size())
      fail_run($sformatf("error %s: expected %0d mul results, actual %0d", name,
                         exp_mul.size(), got_mul.size()));
    if (got_br.size() != exp_br.size())
      fail_run($sformatf("error %s: expected %0d branches, actual %0d", name,
                         exp_br.size(), got_br.size()));
    foreach (exp_alu[i]) begin
      check_data(name, exp_alu[i].value, got_alu[i].value);
      check_rob(name, exp_alu[i].rob, got_alu[i].rob);
    end
    foreach (exp_mul[i]) begin
      check_data(name, exp_mul[i].value, got_mul[i].value);
      check_rob(name, exp_mul[i].rob, got_mul[i].rob);
      if (check_latency && exp_mul[i].cycle != got_mul[i].cycle)
        fail_run($sformatf("error %s: expected arrival cycle %0d, actual %0d", name,
                           exp_mul[i].cycle, got_mul[i].cycle));
    end
    foreach (exp_br[i]) begin
      check_bit(name, exp_br[i].taken, got_br[i].taken);
      check_data(name, exp_br[i].value, got_br[i].value);
      check_rob(name, exp_br[i].rob, got_br[i].rob);
    end
    exp_alu.delete();
    got_alu.delete();
    exp_mul.delete();
    got_mul.delete();
    exp_br.delete();
    got_br.delete();
  endtask

  task automatic drain(string name);
    int waited;
    waited = 0;
    while (got_alu.size() < exp_alu.size() || got_mul.size() < exp_mul.size() ||
           got_br.size() < exp_br.size()) begin
      if (waited >= timeout_cycles) begin
        fail_run($sformatf("%s: timed out waiting for results", name));
      end else begin
        waited++;
        @(posedge clock);
      end
    end
    repeat (num_mul_stages + 4) @(posedge clock);  // room for stray extras
    compare_results(name);
  endtask

  task automatic drop_younger(rob_idx_t branch, rob_idx_t tail);
    for (int i = exp_mul.size() - 1; i >= 0; i--) begin
      if (after_branch(exp_mul[i].rob, branch, tail)) exp_mul.delete(i);
    end
    for (int i = exp_alu.size() - 1; i >= 0; i--) begin
      if (after_branch(exp_alu[i].rob, branch, tail)) exp_alu.delete(i);
    end
  endtask

  task automatic test_alu_ops();
    data_t edges[5];
    test_name = "alu ops";
    edges[0] = '0;
    edges[1] = 64'd1;
    edges[2] = 64'h8000_0000_0000_0000;
    edges[3] = '1;
    edges[4] = 64'h7fff_ffff_ffff_ffff;
    for (int op = 0; op < 16; op++) begin
      for (int k = 0; k < 8; k++)
        issue(exec_op_e'(op), br_always, rand64(), rand64(), 1'b0, '0, '0, '0, fresh_rob());
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++)
          issue(exec_op_e'(op), br_always, edges[i], edges[j], 1'b0, '0, '0, '0, fresh_rob());
      end
    end
    idle();
    drain("alu ops");
  endtask

  task automatic test_literal();
    test_name = "literal";
    for (int op = 0; op < 16; op++)
      issue(exec_op_e'(op), br_always, rand64(), rand64(), 1'b1, lit_t'(rand64()), '0, '0,
            fresh_rob());
    for (int k = 0; k < 4; k++)
      issue(op_mulq, br_always, rand64(), rand64(), 1'b1, lit_t'(rand64()), '0, '0, fresh_rob());
    idle();
    drain("literal");
  endtask

  task automatic test_mul_stream();
    test_name     = "mul stream";
    check_latency = 1'b1;
    for (int k = 0; k < 12; k++)
      issue(op_mulq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, fresh_rob());
    idle();
    drain("mul stream");
    check_latency = 1'b0;
  endtask

  task automatic test_back_pressure();
    data_t pick;
    test_name    = "back pressure";
    random_ready = 1'b1;
    for (int k = 0; k < 60; k++) begin
      pick = rand64();
      if (pick[1:0] == 2'b00)
        issue(op_mulq, br_always, rand64(), rand64(), pick[2], pick[15:8], '0, '0, fresh_rob());
      else
        issue(exec_op_e'(pick[7:4]), br_always, rand64(), rand64(), pick[2], pick[15:8],
              '0, '0, fresh_rob());
    end
    idle();
    drain("back pressure");
    random_ready = 1'b0;
    @(posedge clock);
    alu_ready <= 1'b1;
    mul_ready <= 1'b1;
    @(posedge clock);
  endtask

  task automatic test_branches();
    data_t vals[5];
    test_name = "branches";
    vals[0] = '0;
    vals[1] = 64'hffff_ffff_ffff_fffa;  // -6
    vals[2] = 64'hffff_ffff_ffff_fffb;  // -5
    vals[3] = 64'd8;
    vals[4] = 64'd7;
    for (int c = 0; c < 9; c++) begin
      for (int v = 0; v < 5; v++) begin
        issue(op_br, br_cond_e'(c), vals[v], '0, 1'b0, '0, disp_t'(rand64()), rand64(),
              fresh_rob());
        idle();  // keeps the next issue out of a rollback cycle
      end
    end
    drain("branches");
  endtask

  task automatic test_rollback();
    test_name = "rollback";
    // taken at 30 with tail 1, so indices wrap
    rob_tail_idx <= 5'd1;
    alu_ready    <= 1'b0;  // younger alu result sits in the register
    issue(op_mulq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd29);
    issue(op_mulq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd31);
    issue(op_subq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd0);
    issue(op_br, br_always, '0, '0, 1'b0, '0, disp_t'(rand64()), rand64(), 5'd30);
    issue(op_mulq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd1);  // rollback cycle
    idle();
    alu_ready <= 1'b1;
    drop_younger(5'd30, 5'd1);
    drain("rollback taken");
    rob_tail_idx <= 5'd6;
    issue(op_mulq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd3);
    issue(op_br, br_ne, '0, '0, 1'b0, '0, disp_t'(rand64()), rand64(), 5'd2);
    issue(op_xor, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd4);
    issue(op_mulq, br_always, rand64(), rand64(), 1'b0, '0, '0, '0, 5'd5);
    idle();
    drain("rollback not taken");
  endtask

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    issue_valid   = 1'b0;
    issue_op      = op_addq;
    issue_cond    = br_always;
    issue_a       = '0;
    issue_b       = '0;
    issue_use_lit = 1'b0;
    issue_lit     = '0;
    issue_disp    = '0;
    issue_npc     = '0;
    issue_rob_idx = '0;
    alu_ready     = 1'b1;
    mul_ready     = 1'b1;
    rob_tail_idx  = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    test_alu_ops();
    test_literal();
    test_mul_stream();
    test_back_pressure();
    test_branches();
    test_rollback();
    if (dut_i.props_i.fail_count != 0) begin
      $display("*** TEST FAILED ***");
      $fatal(1);
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule
